// ==== rv_decode_consts.svh ====
// ================================================
// Fixed widths and encodings for the RV32I decoder.
// Include it in any file that needs an ISA width,
// an opcode value or a funct7 value.
// ================================================

`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// datapath widths, all fixed by the ISA
`define RV_XLEN    32   // data and immediate width
`define RV_ADDR_W  32   // instruction address width
`define RV_REG_AW  5    // x0..x31
`define RV_OPC_W   7

// base opcode map, bits [6:0] of the word
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_LOAD    7'b0000011
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_OP      7'b0110011

// funct7 values accepted by op and the immediate shifts
// ALT selects sub and the arithmetic right shift
`define RV_F7_BASE  7'b0000000
`define RV_F7_ALT   7'b0100000

`endif

// ==== rv_decode_pkg.sv ====
// ================================================
// Types shared by the decoder stages and the
// testbench: operation enums and the records that
// travel between capture, classify and output.
// ================================================

`include "rv_decode_consts.svh"

package rv_decode_pkg;

    // supported major opcodes, anything else is illegal
    typedef enum logic [`RV_OPC_W-1:0] {
        OPC_LUI    = `RV_OPC_LUI,
        OPC_AUIPC  = `RV_OPC_AUIPC,
        OPC_JAL    = `RV_OPC_JAL,
        OPC_JALR   = `RV_OPC_JALR,
        OPC_BRANCH = `RV_OPC_BRANCH,
        OPC_LOAD   = `RV_OPC_LOAD,
        OPC_STORE  = `RV_OPC_STORE,
        OPC_OP_IMM = `RV_OPC_OP_IMM,
        OPC_OP     = `RV_OPC_OP
    } rv_opcode_e;

    typedef enum logic [1:0] {
        GRP_NONE, GRP_ALU, GRP_BJP, GRP_MEM
    } dec_grp_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [2:0] {
        BJP_NONE, BJP_JUMP, BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU
    } bjp_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    // jalr shares the I immediate
    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_sel_e;

    // registered instruction split into its fields
    typedef struct packed {
        logic                  valid;
        logic [`RV_ADDR_W-1:0] inst_addr;
        logic [`RV_XLEN-1:0]   inst;
        logic [`RV_OPC_W-1:0]  opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
    } inst_fields_t;

    // classifier result, all zero for an illegal word
    typedef struct packed {
        dec_grp_e grp;
        alu_op_e  alu_op;
        bjp_op_e  bjp_op;
        mem_op_e  mem_op;
        imm_sel_e imm_sel;
        logic     op2_imm;
        logic     op1_pc;
        logic     uses_rs1;
        logic     uses_rs2;
        logic     writes_rd;
        logic     illegal;
    } dec_info_t;

    // decode record presented at the top level
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        dec_grp_e              grp;
        alu_op_e               alu_op;
        bjp_op_e               bjp_op;
        mem_op_e               mem_op;
        logic                  op2_imm;
        logic                  op1_pc;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_ADDR_W-1:0] inst_addr;
        logic [`RV_REG_AW-1:0] rs1_addr;
        logic                  rs1_re;
        logic [`RV_REG_AW-1:0] rs2_addr;
        logic                  rs2_re;
        logic [`RV_REG_AW-1:0] rd_addr;
        logic                  rd_we;
    } dec_out_t;

endpackage

// ==== inst_capture.sv ====
// ================================================
// Input stage of the decoder. Samples the word, its
// address and the valid strobe every cycle and hands
// the split fields to the classifier and imm_gen.
// ================================================

`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module inst_capture import rv_decode_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [`RV_XLEN-1:0]   inst_i,
    input  logic [`RV_ADDR_W-1:0] inst_addr_i,
    input  logic                  inst_valid_i,
    output inst_fields_t          fields_o
);

    logic                  valid_q;
    logic [`RV_XLEN-1:0]   inst_q;
    logic [`RV_ADDR_W-1:0] addr_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= inst_valid_i;
        end
    end

    // payload taken unconditionally, valid_q qualifies it
    always_ff @(posedge clk_i) begin
        inst_q <= inst_i;
        addr_q <= inst_addr_i;
    end

    // standard RV32 field positions
    always_comb begin
        fields_o.valid     = valid_q;
        fields_o.inst_addr = addr_q;
        fields_o.inst      = inst_q;
        fields_o.opcode    = inst_q[6:0];
        fields_o.funct3    = inst_q[14:12];
        fields_o.funct7    = inst_q[31:25];
        fields_o.rs1       = inst_q[19:15];
        fields_o.rs2       = inst_q[24:20];
        fields_o.rd        = inst_q[11:7];
    end

endmodule

// ==== inst_classify.sv ====
// ================================================
// Combinational classifier. Maps opcode, funct3 and
// funct7 to a group, an operation code, the operand
// flags and the register use flags. Unsupported or
// malformed words come out all zero with illegal set.
// ================================================

`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module inst_classify import rv_decode_pkg::*; (
    input  inst_fields_t fields_i,
    output dec_info_t    info_o
);

    rv_opcode_e opc;
    logic [2:0] f3;
    logic       f7_base;
    logic       f7_alt;
    logic       bad;

    assign opc     = rv_opcode_e'(fields_i.opcode);
    assign f3      = fields_i.funct3;
    assign f7_base = (fields_i.funct7 == `RV_F7_BASE);
    assign f7_alt  = (fields_i.funct7 == `RV_F7_ALT);

    always_comb begin
        info_o = '0;
        bad    = 1'b0;
        case (opc)
            OPC_LUI: begin
                info_o.grp       = GRP_ALU;
                info_o.alu_op    = ALU_LUI;
                info_o.imm_sel   = IMM_U;
                info_o.op2_imm   = 1'b1;
                info_o.writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                info_o.grp       = GRP_ALU;
                info_o.alu_op    = ALU_AUIPC;
                info_o.imm_sel   = IMM_U;
                info_o.op2_imm   = 1'b1;
                info_o.op1_pc    = 1'b1;   // pc + imm
                info_o.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                info_o.grp       = GRP_BJP;
                info_o.bjp_op    = BJP_JUMP;
                info_o.imm_sel   = IMM_J;
                info_o.writes_rd = 1'b1;
            end
            OPC_JALR: begin
                info_o.grp       = GRP_BJP;
                info_o.bjp_op    = BJP_JUMP;
                info_o.imm_sel   = IMM_I;
                info_o.uses_rs1  = 1'b1;
                info_o.writes_rd = 1'b1;
                bad              = (f3 != 3'b000);
            end
            OPC_BRANCH: begin
                info_o.grp      = GRP_BJP;
                info_o.imm_sel  = IMM_B;
                info_o.uses_rs1 = 1'b1;
                info_o.uses_rs2 = 1'b1;
                case (f3)
                    3'b000:  info_o.bjp_op = BJP_BEQ;
                    3'b001:  info_o.bjp_op = BJP_BNE;
                    3'b100:  info_o.bjp_op = BJP_BLT;
                    3'b101:  info_o.bjp_op = BJP_BGE;
                    3'b110:  info_o.bjp_op = BJP_BLTU;
                    3'b111:  info_o.bjp_op = BJP_BGEU;
                    default: bad = 1'b1;   // 010, 011
                endcase
            end
            OPC_LOAD: begin
                info_o.grp       = GRP_MEM;
                info_o.imm_sel   = IMM_I;
                info_o.uses_rs1  = 1'b1;
                info_o.writes_rd = 1'b1;
                case (f3)
                    3'b000:  info_o.mem_op = MEM_LB;
                    3'b001:  info_o.mem_op = MEM_LH;
                    3'b010:  info_o.mem_op = MEM_LW;
                    3'b100:  info_o.mem_op = MEM_LBU;
                    3'b101:  info_o.mem_op = MEM_LHU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_STORE: begin
                info_o.grp      = GRP_MEM;
                info_o.imm_sel  = IMM_S;
                info_o.uses_rs1 = 1'b1;
                info_o.uses_rs2 = 1'b1;
                case (f3)
                    3'b000:  info_o.mem_op = MEM_SB;
                    3'b001:  info_o.mem_op = MEM_SH;
                    3'b010:  info_o.mem_op = MEM_SW;
                    default: bad = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                info_o.grp       = GRP_ALU;
                info_o.imm_sel   = IMM_I;
                info_o.op2_imm   = 1'b1;
                info_o.uses_rs1  = 1'b1;
                info_o.writes_rd = 1'b1;
                case (f3)
                    3'b000: info_o.alu_op = ALU_ADD;   // addi, nop included
                    3'b010: info_o.alu_op = ALU_SLT;
                    3'b011: info_o.alu_op = ALU_SLTU;
                    3'b100: info_o.alu_op = ALU_XOR;
                    3'b110: info_o.alu_op = ALU_OR;
                    3'b111: info_o.alu_op = ALU_AND;
                    3'b001: begin
                        info_o.alu_op  = ALU_SLL;
                        info_o.imm_sel = IMM_SHAMT;
                        bad            = !f7_base;
                    end
                    default: begin   // srli / srai
                        info_o.alu_op  = f7_alt ? ALU_SRA : ALU_SRL;
                        info_o.imm_sel = IMM_SHAMT;
                        bad            = !(f7_base || f7_alt);
                    end
                endcase
            end
            OPC_OP: begin
                info_o.grp       = GRP_ALU;
                info_o.uses_rs1  = 1'b1;
                info_o.uses_rs2  = 1'b1;
                info_o.writes_rd = 1'b1;
                case (f3)
                    3'b000:  info_o.alu_op = f7_alt ? ALU_SUB : ALU_ADD;
                    3'b001:  info_o.alu_op = ALU_SLL;
                    3'b010:  info_o.alu_op = ALU_SLT;
                    3'b011:  info_o.alu_op = ALU_SLTU;
                    3'b100:  info_o.alu_op = ALU_XOR;
                    3'b101:  info_o.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    3'b110:  info_o.alu_op = ALU_OR;
                    default: info_o.alu_op = ALU_AND;
                endcase
                // ALT only legal for add/sub and the right shifts
                bad = !(f7_base || (f7_alt && (f3 == 3'b000 || f3 == 3'b101)));
            end
            default: bad = 1'b1;   // fence, system, csr, unknown
        endcase

        if (bad) begin
            info_o = '0;
        end
        info_o.illegal = bad && fields_i.valid;
    end

endmodule

// ==== imm_gen.sv ====
// ================================================
// Immediate builder. Forms every RV32I immediate
// from the captured word and returns the one the
// classifier asks for, zero when none is used.
// ================================================

`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module imm_gen import rv_decode_pkg::*; (
    input  inst_fields_t        fields_i,
    input  imm_sel_e            imm_sel_i,
    output logic [`RV_XLEN-1:0] imm_o
);

    logic [`RV_XLEN-1:0] inst;
    logic [`RV_XLEN-1:0] imm_i_w;
    logic [`RV_XLEN-1:0] imm_s_w;
    logic [`RV_XLEN-1:0] imm_b_w;
    logic [`RV_XLEN-1:0] imm_u_w;
    logic [`RV_XLEN-1:0] imm_j_w;
    logic [`RV_XLEN-1:0] imm_sh_w;

    assign inst = fields_i.inst;

    // sign bit is always inst[31]
    assign imm_i_w = {{20{inst[31]}}, inst[31:20]};
    assign imm_s_w = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b_w = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u_w = {inst[31:12], 12'h000};
    assign imm_j_w = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // shift amount, zero extended
    assign imm_sh_w = {27'h0, inst[24:20]};

    always_comb begin
        case (imm_sel_i)
            IMM_I:     imm_o = imm_i_w;
            IMM_S:     imm_o = imm_s_w;
            IMM_B:     imm_o = imm_b_w;
            IMM_U:     imm_o = imm_u_w;
            IMM_J:     imm_o = imm_j_w;
            IMM_SHAMT: imm_o = imm_sh_w;
            default:   imm_o = '0;
        endcase
    end

endmodule

// ==== dec_out_stage.sv ====
// ================================================
// Output stage of the decoder. Applies the x0 rules
// to the register ports and registers the complete
// decode record. The record is live one cycle after
// the classifier result and must be taken then.
// ================================================

`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module dec_out_stage import rv_decode_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  inst_fields_t        fields_i,
    input  dec_info_t           info_i,
    input  logic [`RV_XLEN-1:0] imm_i,
    output dec_out_t            dec_out_o
);

    dec_out_t out_d;
    logic     rd_we;

    // x0 is never written
    assign rd_we = info_i.writes_rd && (fields_i.rd != '0);

    always_comb begin
        out_d.valid     = fields_i.valid;
        out_d.illegal   = info_i.illegal;
        out_d.grp       = info_i.grp;
        out_d.alu_op    = info_i.alu_op;
        out_d.bjp_op    = info_i.bjp_op;
        out_d.mem_op    = info_i.mem_op;
        out_d.op2_imm   = info_i.op2_imm;
        out_d.op1_pc    = info_i.op1_pc;
        out_d.imm       = imm_i;
        out_d.inst_addr = fields_i.inst_addr;

        // unused read ports show address 0
        out_d.rs1_addr = info_i.uses_rs1 ? fields_i.rs1 : '0;
        out_d.rs2_addr = info_i.uses_rs2 ? fields_i.rs2 : '0;
        out_d.rs1_re   = info_i.uses_rs1 && (fields_i.rs1 != '0);
        out_d.rs2_re   = info_i.uses_rs2 && (fields_i.rs2 != '0);

        out_d.rd_addr = rd_we ? fields_i.rd : '0;
        out_d.rd_we   = rd_we;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_out_o.valid   <= 1'b0;
            dec_out_o.illegal <= 1'b0;
            dec_out_o.rs1_re  <= 1'b0;
            dec_out_o.rs2_re  <= 1'b0;
            dec_out_o.rd_we   <= 1'b0;
        end else begin
            dec_out_o <= out_d;
        end
    end

endmodule

// ==== rv_decoder_top.sv ====
// ================================================
// RV32I decoder top level. Two register stages, so
// a word accepted with inst_valid_i high comes out
// on dec_out_o two cycles later. No back-pressure.
// ================================================

`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module rv_decoder_top import rv_decode_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [`RV_XLEN-1:0]   inst_i,
    input  logic [`RV_ADDR_W-1:0] inst_addr_i,
    input  logic                  inst_valid_i,
    output dec_out_t              dec_out_o
);

    inst_fields_t        fields;
    dec_info_t           info;
    logic [`RV_XLEN-1:0] imm;

    inst_capture i_inst_capture (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .inst_valid_i (inst_valid_i),
        .fields_o     (fields)
    );

    inst_classify i_inst_classify (
        .fields_i (fields),
        .info_o   (info)
    );

    imm_gen i_imm_gen (
        .fields_i  (fields),
        .imm_sel_i (info.imm_sel),
        .imm_o     (imm)
    );

    dec_out_stage i_dec_out_stage (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .fields_i  (fields),
        .info_i    (info),
        .imm_i     (imm),
        .dec_out_o (dec_out_o)
    );

endmodule

// ==== tb_rv_decoder.sv ====
// ================================================
// Testbench for the RV32I decoder. Drives random
// instruction words from an xorshift generator and
// checks each decode record two cycles later against
// a model of the decode rules. Run from sim.f.
// ================================================

`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module tb_rv_decoder import rv_decode_pkg::*; ();

    localparam int          NUM_INST     = 2000;   // words driven, about 80% valid
    localparam int          RESET_CYCLES = 10;
    localparam int          TIMEOUT      = NUM_INST + RESET_CYCLES + 50;
    localparam logic [31:0] SEED         = 32'h325b662a;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic        inst_valid_i;
    dec_out_t    dec_out_o;

    logic [31:0] rng_state;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          cycle_cnt = 0;
    dec_out_t    exp_q[$];   // expected records in issue order

    rv_decoder_top i_rv_decoder_top (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .inst_valid_i (inst_valid_i),
        .dec_out_o    (dec_out_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    function automatic logic [6:0] kept_opcode(input int k);
        case (k)
            0:       return `RV_OPC_LUI;
            1:       return `RV_OPC_AUIPC;
            2:       return `RV_OPC_JAL;
            3:       return `RV_OPC_JALR;
            4:       return `RV_OPC_BRANCH;
            5:       return `RV_OPC_LOAD;
            6:       return `RV_OPC_STORE;
            7:       return `RV_OPC_OP_IMM;
            default: return `RV_OPC_OP;
        endcase
    endfunction

    // opcode mix with funct7 and register fields biased toward interesting values
    task automatic build_word(output logic [31:0] w);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        draw(r0);
        draw(r1);
        draw(r2);
        case (r0[1:0])
            2'd0, 2'd1: opc = kept_opcode(r1 % 9);
            2'd2:       opc = r1[0] ? 7'b0001111 : 7'b1110011;   // fence, system
            default:    opc = r1[6:0];
        endcase
        case (r2[1:0])
            2'd0:    f7 = `RV_F7_BASE;
            2'd1:    f7 = `RV_F7_ALT;
            default: f7 = r2[8:2];
        endcase
        rd  = (r2[11:9] == 3'd0) ? 5'd0 : r2[16:12];
        rs1 = (r2[19:17] == 3'd0) ? 5'd0 : r2[24:20];
        rs2 = (r1[15:13] == 3'd0) ? 5'd0 : r1[12:8];
        w = {f7, rs2, rs1, r1[18:16], rd, opc};
        if (r0[1:0] == 2'd3 && r0[2]) begin
            w = r1 ^ r2;   // fully random bits
        end
    endtask

    function automatic alu_op_e base_alu(input logic [2:0] f3);
        case (f3)
            3'b000:  return ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // expected record for a valid word
    function automatic dec_out_t model_decode(input logic [31:0] w, input logic [31:0] pc);
        dec_out_t   r;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        logic       use1;
        logic       use2;
        logic       wr;
        r    = '0;
        f3   = w[14:12];
        f7   = w[31:25];
        ok   = 1'b1;
        use1 = 1'b0;
        use2 = 1'b0;
        wr   = 1'b0;
        case (w[6:0])
            `RV_OPC_LUI, `RV_OPC_AUIPC: begin
                r.grp     = GRP_ALU;
                r.alu_op  = (w[6:0] == `RV_OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                r.op1_pc  = (w[6:0] == `RV_OPC_AUIPC);
                r.op2_imm = 1'b1;
                r.imm     = {w[31:12], 12'h000};
                wr        = 1'b1;
            end
            `RV_OPC_JAL: begin
                r.grp    = GRP_BJP;
                r.bjp_op = BJP_JUMP;
                r.imm    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                wr       = 1'b1;
            end
            `RV_OPC_JALR: begin
                r.grp    = GRP_BJP;
                r.bjp_op = BJP_JUMP;
                r.imm    = {{20{w[31]}}, w[31:20]};
                use1     = 1'b1;
                wr       = 1'b1;
                ok       = (f3 == 3'b000);
            end
            `RV_OPC_BRANCH: begin
                r.grp = GRP_BJP;
                r.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                use1  = 1'b1;
                use2  = 1'b1;
                case (f3)
                    3'b000:  r.bjp_op = BJP_BEQ;
                    3'b001:  r.bjp_op = BJP_BNE;
                    3'b100:  r.bjp_op = BJP_BLT;
                    3'b101:  r.bjp_op = BJP_BGE;
                    3'b110:  r.bjp_op = BJP_BLTU;
                    3'b111:  r.bjp_op = BJP_BGEU;
                    default: ok = 1'b0;
                endcase
            end
            `RV_OPC_LOAD: begin
                r.grp = GRP_MEM;
                r.imm = {{20{w[31]}}, w[31:20]};
                use1  = 1'b1;
                wr    = 1'b1;
                case (f3)
                    3'b000:  r.mem_op = MEM_LB;
                    3'b001:  r.mem_op = MEM_LH;
                    3'b010:  r.mem_op = MEM_LW;
                    3'b100:  r.mem_op = MEM_LBU;
                    3'b101:  r.mem_op = MEM_LHU;
                    default: ok = 1'b0;
                endcase
            end
            `RV_OPC_STORE: begin
                r.grp = GRP_MEM;
                r.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                use1  = 1'b1;
                use2  = 1'b1;
                case (f3)
                    3'b000:  r.mem_op = MEM_SB;
                    3'b001:  r.mem_op = MEM_SH;
                    3'b010:  r.mem_op = MEM_SW;
                    default: ok = 1'b0;
                endcase
            end
            `RV_OPC_OP_IMM: begin
                r.grp     = GRP_ALU;
                r.alu_op  = base_alu(f3);
                r.op2_imm = 1'b1;
                r.imm     = {{20{w[31]}}, w[31:20]};
                use1      = 1'b1;
                wr        = 1'b1;
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    r.imm = {27'd0, w[24:20]};   // shamt only
                    ok    = (f7 == `RV_F7_BASE) || (f3 == 3'b101 && f7 == `RV_F7_ALT);
                    if (f3 == 3'b101 && f7 == `RV_F7_ALT) begin
                        r.alu_op = ALU_SRA;
                    end
                end
            end
            `RV_OPC_OP: begin
                r.grp    = GRP_ALU;
                r.alu_op = base_alu(f3);
                use1     = 1'b1;
                use2     = 1'b1;
                wr       = 1'b1;
                if (f7 == `RV_F7_ALT) begin
                    ok       = (f3 == 3'b000) || (f3 == 3'b101);
                    r.alu_op = (f3 == 3'b000) ? ALU_SUB : ALU_SRA;
                end else begin
                    ok = (f7 == `RV_F7_BASE);
                end
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            r         = '0;
            r.illegal = 1'b1;
            use1      = 1'b0;
            use2      = 1'b0;
            wr        = 1'b0;
        end
        r.valid     = 1'b1;
        r.inst_addr = pc;
        r.rs1_re    = use1 && (w[19:15] != 5'd0);
        r.rs1_addr  = use1 ? w[19:15] : 5'd0;
        r.rs2_re    = use2 && (w[24:20] != 5'd0);
        r.rs2_addr  = use2 ? w[24:20] : 5'd0;
        r.rd_we     = wr && (w[11:7] != 5'd0);
        r.rd_addr   = r.rd_we ? w[11:7] : 5'd0;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_record(input dec_out_t got, input dec_out_t exp);
        check_value("dec_out_o.valid", 32'(got.valid), 32'(exp.valid));
        if (exp.valid) begin   // payload only means something when valid
            check_value("dec_out_o.illegal", 32'(got.illegal), 32'(exp.illegal));
            check_value("dec_out_o.grp", 32'(got.grp), 32'(exp.grp));
            check_value("dec_out_o.alu_op", 32'(got.alu_op), 32'(exp.alu_op));
            check_value("dec_out_o.bjp_op", 32'(got.bjp_op), 32'(exp.bjp_op));
            check_value("dec_out_o.mem_op", 32'(got.mem_op), 32'(exp.mem_op));
            check_value("dec_out_o.op2_imm", 32'(got.op2_imm), 32'(exp.op2_imm));
            check_value("dec_out_o.op1_pc", 32'(got.op1_pc), 32'(exp.op1_pc));
            check_value("dec_out_o.imm", got.imm, exp.imm);
            check_value("dec_out_o.inst_addr", got.inst_addr, exp.inst_addr);
            check_value("dec_out_o.rs1_addr", 32'(got.rs1_addr), 32'(exp.rs1_addr));
            check_value("dec_out_o.rs1_re", 32'(got.rs1_re), 32'(exp.rs1_re));
            check_value("dec_out_o.rs2_addr", 32'(got.rs2_addr), 32'(exp.rs2_addr));
            check_value("dec_out_o.rs2_re", 32'(got.rs2_re), 32'(exp.rs2_re));
            check_value("dec_out_o.rd_addr", 32'(got.rd_addr), 32'(exp.rd_addr));
            check_value("dec_out_o.rd_we", 32'(got.rd_we), 32'(exp.rd_we));
        end
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] addr;
        logic [31:0] r;
        logic        vld;
        dec_out_t    exp;
        rst_n_i      = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        inst_valid_i = 1'b0;
        rng_state    = SEED;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        @(negedge clk_i);
        check_value("dec_out_o.valid", 32'(dec_out_o.valid), 32'd0);
        check_value("dec_out_o.illegal", 32'(dec_out_o.illegal), 32'd0);
        check_value("dec_out_o.rd_we", 32'(dec_out_o.rd_we), 32'd0);
        check_value("dec_out_o.rs1_re", 32'(dec_out_o.rs1_re), 32'd0);
        check_value("dec_out_o.rs2_re", 32'(dec_out_o.rs2_re), 32'd0);

        // three extra idle words drain the pipe
        for (int n = 0; n < NUM_INST + 3; n++) begin
            @(posedge clk_i);
            word = '0;
            addr = '0;
            vld  = 1'b0;
            if (n < NUM_INST) begin
                build_word(word);
                draw(addr);
                draw(r);
                vld = (r % 10) < 8;
            end
            inst_i       <= word;
            inst_addr_i  <= addr;
            inst_valid_i <= vld;
            exp = vld ? model_decode(word, addr) : '0;
            exp_q.push_back(exp);
            @(negedge clk_i);
            if (exp_q.size() == 3) begin   // output lags the drive edge by two edges
                compare_record(dec_out_o, exp_q.pop_front());
            end
        end

        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+.
rv_decode_pkg.sv
inst_capture.sv
inst_classify.sv
imm_gen.sv
dec_out_stage.sv
rv_decoder_top.sv
tb_rv_decoder.sv

// ==== Makefile ====
# Verilator build and run of the RV32I decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_decoder
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) VFLAGS=\"$(VFLAGS)\""

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(BUILD_DIR)
